// File: source/kernel_cu_pkg.sv
/* Graph compute unit shared definitions */

package kernel_cu_pkg;

  // ----------------------------------------
  // Memory port widths
  // ----------------------------------------
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int SUM_W  = 32;

  // Requestors sharing the memory port
  localparam int NUM_REQUESTORS = 2;
  localparam int ID_W           = 1;
  localparam int ID_SETUP       = 0;
  localparam int ID_REDUCE      = 1;

  // ----------------------------------------
  // Configuration block layout
  // ----------------------------------------
  localparam int CFG_WORDS        = 2;
  localparam int CFG_VERTEX_BASE  = 0;
  localparam int CFG_VERTEX_COUNT = 1;

  // Read request as held in the request FIFO
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
  } mem_request_t;

  // Read response tagged with its requestor
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [ID_W-1:0]   id;
  } mem_response_t;

endpackage : kernel_cu_pkg

// File: source/sync_fifo.sv
/* Synchronous FIFO */

`timescale 1ns/100ps

module sync_fifo #(
  parameter type payload_t  = logic,
  parameter int  FIFO_DEPTH = 8
) (
  input  logic     ap_clk,
  input  logic     areset_control,
  input  logic     wr_en,
  input  payload_t wr_data,
  input  logic     rd_en,
  output payload_t rd_data,
  output logic     empty,
  output logic     prog_full
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  payload_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;
  logic             full;

  assign full      = (count == CNT_W'(FIFO_DEPTH));
  assign empty     = (count == '0);
  // Two entries of headroom for requests already granted
  assign prog_full = (count >= CNT_W'(FIFO_DEPTH - 2));
  // Writes to a full or reads from an empty FIFO are dropped
  assign do_wr     = wr_en & ~full;
  assign do_rd     = rd_en & ~empty;
  // Head entry is visible before the pop
  assign rd_data   = mem[rd_ptr];

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
    end
  end

  // Storage array
  always_ff @(posedge ap_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule : sync_fifo

// File: source/request_arbiter.sv
/* Round-robin request arbiter */

`timescale 1ns/100ps

module request_arbiter import kernel_cu_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  logic [NUM_REQUESTORS-1:0] req_valid,
  input  logic [ADDR_W-1:0]         req_addr [NUM_REQUESTORS],
  input  logic                      mem_stall,
  output logic [NUM_REQUESTORS-1:0] req_grant,
  output logic                      mem_req_valid,
  output mem_request_t              mem_req,
  output logic                      empty
);

  logic [ID_W-1:0] rr_ptr;
  logic [ID_W-1:0] scan_id;
  logic [ID_W-1:0] grant_id;
  logic            found;
  logic            prog_full;
  logic            fifo_wr;
  logic            fifo_pop;
  mem_request_t    wr_req;

  // ----------------------------------------
  // Pick first waiting engine from rr_ptr
  // ----------------------------------------
  always_comb begin
    found    = 1'b0;
    grant_id = rr_ptr;
    scan_id  = rr_ptr;
    for (int k = 0; k < NUM_REQUESTORS; k++) begin
      scan_id = ID_W'((int'(rr_ptr) + k) % NUM_REQUESTORS);
      if (!found && req_valid[scan_id]) begin
        found    = 1'b1;
        grant_id = scan_id;
      end
    end
  end

  // No grant once the FIFO is nearly full, engines keep holding
  assign fifo_wr = found & ~prog_full;

  // One-hot grant pulse back to the winner
  always_comb begin
    req_grant           = '0;
    req_grant[grant_id] = fifo_wr;
  end

  // Tag the granted address with its requestor ID
  assign wr_req = '{addr: req_addr[grant_id], id: grant_id};

  // Memory side drains unless stalled
  assign fifo_pop      = ~mem_stall & ~empty;
  assign mem_req_valid = fifo_pop;

  // Winner drops to lowest priority
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rr_ptr <= '0;
    end else if (fifo_wr) begin
      rr_ptr <= ID_W'((int'(grant_id) + 1) % NUM_REQUESTORS);
    end
  end

  sync_fifo #(
    .payload_t (mem_request_t),
    .FIFO_DEPTH(FIFO_DEPTH   )
  ) inst_request_fifo (
    .ap_clk        (ap_clk        ),
    .areset_control(areset_control),
    .wr_en         (fifo_wr       ),
    .wr_data       (wr_req        ),
    .rd_en         (fifo_pop      ),
    .rd_data       (mem_req       ),
    .empty         (empty         ),
    .prog_full     (prog_full     )
  );

endmodule : request_arbiter

// File: source/response_router.sv
/* Response router */

`timescale 1ns/100ps

module response_router import kernel_cu_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  logic                      mem_resp_valid,
  input  mem_response_t             mem_resp,
  output logic [NUM_REQUESTORS-1:0] resp_valid,
  output logic [DATA_W-1:0]         resp_data,
  output logic                      empty
);

  mem_response_t head;
  logic          fifo_pop;

  // Engines always accept, so drain one entry every cycle
  assign fifo_pop  = ~empty;
  assign resp_data = head.data;

  // ----------------------------------------
  // Steer the pop to the tagged engine
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      resp_valid[i] = fifo_pop & (head.id == ID_W'(i));
    end
  end

  sync_fifo #(
    .payload_t (mem_response_t),
    .FIFO_DEPTH(FIFO_DEPTH    )
  ) inst_response_fifo (
    .ap_clk        (ap_clk        ),
    .areset_control(areset_control),
    .wr_en         (mem_resp_valid),
    .wr_data       (mem_resp      ),
    .rd_en         (fifo_pop      ),
    .rd_data       (head          ),
    .empty         (empty         ),
    // Drained every cycle so occupancy stays at one or below
    .prog_full     (              )
  );

endmodule : response_router

// File: source/cu_setup.sv
/* Configuration setup engine */

`timescale 1ns/100ps

module cu_setup import kernel_cu_pkg::*; (
  input  logic              ap_clk,
  input  logic              areset_control,
  input  logic              descriptor_valid,
  input  logic [ADDR_W-1:0] config_base,
  input  logic              resp_valid,
  input  logic [DATA_W-1:0] resp_data,
  input  logic              req_grant,
  input  logic              flush,
  output logic              req_valid,
  output logic [ADDR_W-1:0] req_addr,
  output logic [ADDR_W-1:0] vertex_base,
  output logic [DATA_W-1:0] vertex_count,
  output logic              config_valid,
  output logic              done
);

  localparam int CNT_W = $clog2(CFG_WORDS + 1);

  typedef enum logic [2:0] {
    SETUP_IDLE,
    SETUP_REQUEST,
    SETUP_WAIT,
    SETUP_CONFIGURED,
    SETUP_DONE
  } setup_state_t;

  setup_state_t      state;
  logic [ADDR_W-1:0] base_reg;
  logic [CNT_W-1:0]  req_cnt;
  logic [CNT_W-1:0]  resp_cnt;

  // Config words are read at consecutive addresses
  assign req_valid = (state == SETUP_REQUEST);
  assign req_addr  = base_reg + ADDR_W'(req_cnt);
  assign done      = (state == SETUP_DONE);

  // ----------------------------------------
  // Setup FSM
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state        <= SETUP_IDLE;
      req_cnt      <= '0;
      resp_cnt     <= '0;
      config_valid <= 1'b0;
    end else begin
      config_valid <= 1'b0;
      // Responses may overlap the request phase
      if (resp_valid) begin
        resp_cnt <= resp_cnt + 1'b1;
      end
      case (state)
        SETUP_IDLE: begin
          if (descriptor_valid) begin
            state    <= SETUP_REQUEST;
            req_cnt  <= '0;
            resp_cnt <= '0;
          end
        end
        SETUP_REQUEST: begin
          if (req_grant) begin
            req_cnt <= req_cnt + 1'b1;
            if (req_cnt == CNT_W'(CFG_WORDS - 1)) begin
              state <= SETUP_WAIT;
            end
          end
        end
        SETUP_WAIT: begin
          if (resp_cnt == CNT_W'(CFG_WORDS)) begin
            state        <= SETUP_CONFIGURED;
            config_valid <= 1'b1;
          end
        end
        // Held until the reduction has drained
        SETUP_CONFIGURED: begin
          if (flush) begin
            state <= SETUP_DONE;
          end
        end
        default: begin
          state <= SETUP_DONE;
        end
      endcase
    end
  end

  // Latch descriptor base and returned config words
  always_ff @(posedge ap_clk) begin
    if (state == SETUP_IDLE && descriptor_valid) begin
      base_reg <= config_base;
    end
    if (resp_valid && resp_cnt == CNT_W'(CFG_VERTEX_BASE)) begin
      vertex_base <= resp_data[ADDR_W-1:0];
    end
    if (resp_valid && resp_cnt == CNT_W'(CFG_VERTEX_COUNT)) begin
      vertex_count <= resp_data;
    end
  end

endmodule : cu_setup

// File: source/vertex_degree_reduce.sv
/* Vertex degree reduction engine */

`timescale 1ns/100ps

module vertex_degree_reduce import kernel_cu_pkg::*; (
  input  logic              ap_clk,
  input  logic              areset_control,
  input  logic              config_valid,
  input  logic [ADDR_W-1:0] vertex_base,
  input  logic [DATA_W-1:0] vertex_count,
  input  logic              req_grant,
  input  logic              resp_valid,
  input  logic [DATA_W-1:0] resp_data,
  output logic              req_valid,
  output logic [ADDR_W-1:0] req_addr,
  output logic [SUM_W-1:0]  degree_sum,
  output logic              done
);

  typedef enum logic [1:0] {
    REDUCE_IDLE,
    REDUCE_RUN,
    REDUCE_DONE
  } reduce_state_t;

  reduce_state_t     state;
  logic [ADDR_W-1:0] base_reg;
  logic [DATA_W-1:0] count_reg;
  logic [DATA_W-1:0] issue_cnt;
  logic [DATA_W-1:0] recv_cnt;

  // Next degree word to fetch
  assign req_addr = base_reg + issue_cnt[ADDR_W-1:0];
  assign done     = (state == REDUCE_DONE);

  // ----------------------------------------
  // Issue, count and accumulate
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state      <= REDUCE_IDLE;
      req_valid  <= 1'b0;
      issue_cnt  <= '0;
      recv_cnt   <= '0;
      degree_sum <= '0;
    end else begin
      case (state)
        REDUCE_IDLE: begin
          if (config_valid) begin
            issue_cnt  <= '0;
            recv_cnt   <= '0;
            degree_sum <= '0;
            // Empty vertex set finishes at once
            if (vertex_count == '0) begin
              state <= REDUCE_DONE;
            end else begin
              state     <= REDUCE_RUN;
              req_valid <= 1'b1;
            end
          end
        end
        REDUCE_RUN: begin
          if (req_valid && req_grant) begin
            issue_cnt <= issue_cnt + 1'b1;
            if (issue_cnt == count_reg - 1'b1) begin
              req_valid <= 1'b0;
            end
          end
          if (resp_valid) begin
            recv_cnt   <= recv_cnt + 1'b1;
            degree_sum <= degree_sum + SUM_W'(resp_data);
          end
          // All responses in
          if (recv_cnt == count_reg) begin
            state <= REDUCE_DONE;
          end
        end
        default: begin
          state <= REDUCE_DONE;
        end
      endcase
    end
  end

  // Configuration captured with its strobe
  always_ff @(posedge ap_clk) begin
    if (config_valid) begin
      base_reg  <= vertex_base;
      count_reg <= vertex_count;
    end
  end

endmodule : vertex_degree_reduce

// File: source/completion_control.sv
/* Completion hold chains */

`timescale 1ns/100ps

module completion_control #(
  parameter int PULSE_HOLD = 4
) (
  input  logic ap_clk,
  input  logic areset_control,
  input  logic reduce_done,
  input  logic setup_done,
  input  logic fifo_empty,
  output logic flush,
  output logic done_out
);

  // Chain 0 qualifies reduce done, chain 1 setup done
  logic [1:0]            chain_in;
  logic [PULSE_HOLD-1:0] hold [2];
  logic                  fifo_empty_reg;

  assign chain_in = {setup_done, reduce_done};

  // ----------------------------------------
  // Done must hold with empty FIFOs
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      fifo_empty_reg <= 1'b1;
      hold[0]        <= '0;
      hold[1]        <= '0;
      flush          <= 1'b0;
      done_out       <= 1'b0;
    end else begin
      fifo_empty_reg <= fifo_empty;
      for (int c = 0; c < 2; c++) begin
        hold[c] <= {hold[c][PULSE_HOLD-2:0], chain_in[c] & fifo_empty_reg};
      end
      flush    <= &hold[0];
      // Sticky until reset
      done_out <= done_out | (&hold[1]);
    end
  end

endmodule : completion_control

// File: source/kernel_cu_top.sv
/* Graph compute unit top */

`timescale 1ns/100ps

module kernel_cu_top import kernel_cu_pkg::*; #(
  parameter int FIFO_DEPTH = 8,
  parameter int PULSE_HOLD = 4
) (
  input  logic              ap_clk,
  input  logic              areset_control,
  input  logic              descriptor_valid,
  input  logic [ADDR_W-1:0] config_base,
  input  logic              mem_stall,
  input  logic              mem_resp_valid,
  input  logic [DATA_W-1:0] mem_resp_data,
  input  logic [ID_W-1:0]   mem_resp_id,
  output logic              mem_req_valid,
  output logic [ADDR_W-1:0] mem_req_addr,
  output logic [ID_W-1:0]   mem_req_id,
  output logic [SUM_W-1:0]  degree_sum,
  output logic              done_out
);

  // Per-block reset copies
  logic areset_top;
  logic areset_arbiter;
  logic areset_router;
  logic areset_setup;
  logic areset_reduce;
  logic areset_completion;

  // Descriptor pipeline
  logic              descriptor_valid_reg;
  logic              setup_descriptor_valid;
  logic [ADDR_W-1:0] config_base_reg;
  logic [ADDR_W-1:0] setup_config_base;

  // Engine request and response lanes
  logic [NUM_REQUESTORS-1:0] eng_req_valid;
  logic [ADDR_W-1:0]         eng_req_addr [NUM_REQUESTORS];
  logic [NUM_REQUESTORS-1:0] eng_req_grant;
  logic [NUM_REQUESTORS-1:0] eng_resp_valid;
  logic [DATA_W-1:0]         eng_resp_data;

  // Memory boundary
  logic          arb_req_valid;
  mem_request_t  arb_req;
  logic          resp_in_valid;
  mem_response_t resp_in;

  // Setup to reduce and completion
  logic [ADDR_W-1:0] vertex_base;
  logic [DATA_W-1:0] vertex_count;
  logic              config_valid;
  logic              setup_done;
  logic              reduce_done;
  logic              flush;
  logic              arb_empty;
  logic              router_empty;
  logic              fifo_empty;

  // ----------------------------------------
  // Reset fan-out
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    areset_top        <= areset_control;
    areset_arbiter    <= areset_control;
    areset_router     <= areset_control;
    areset_setup      <= areset_control;
    areset_reduce     <= areset_control;
    areset_completion <= areset_control;
  end

  // ----------------------------------------
  // Descriptor and memory port registers
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_top) begin
      descriptor_valid_reg   <= 1'b0;
      setup_descriptor_valid <= 1'b0;
      mem_req_valid          <= 1'b0;
      resp_in_valid          <= 1'b0;
    end else begin
      descriptor_valid_reg   <= descriptor_valid;
      setup_descriptor_valid <= descriptor_valid_reg;
      mem_req_valid          <= arb_req_valid;
      resp_in_valid          <= mem_resp_valid;
    end
  end

  // Payload stages
  always_ff @(posedge ap_clk) begin
    config_base_reg   <= config_base;
    setup_config_base <= config_base_reg;
    mem_req_addr      <= arb_req.addr;
    mem_req_id        <= arb_req.id;
    resp_in           <= '{data: mem_resp_data, id: mem_resp_id};
  end

  // Both shared FIFOs drained
  assign fifo_empty = arb_empty & router_empty;

  request_arbiter #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) inst_request_arbiter (
    .ap_clk        (ap_clk        ),
    .areset_control(areset_arbiter),
    .req_valid     (eng_req_valid ),
    .req_addr      (eng_req_addr  ),
    .mem_stall     (mem_stall     ),
    .req_grant     (eng_req_grant ),
    .mem_req_valid (arb_req_valid ),
    .mem_req       (arb_req       ),
    .empty         (arb_empty     )
  );

  response_router #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) inst_response_router (
    .ap_clk        (ap_clk        ),
    .areset_control(areset_router ),
    .mem_resp_valid(resp_in_valid ),
    .mem_resp      (resp_in       ),
    .resp_valid    (eng_resp_valid),
    .resp_data     (eng_resp_data ),
    .empty         (router_empty  )
  );

  cu_setup inst_cu_setup (
    .ap_clk          (ap_clk                  ),
    .areset_control  (areset_setup            ),
    .descriptor_valid(setup_descriptor_valid  ),
    .config_base     (setup_config_base       ),
    .resp_valid      (eng_resp_valid[ID_SETUP]),
    .resp_data       (eng_resp_data           ),
    .req_grant       (eng_req_grant[ID_SETUP] ),
    .flush           (flush                   ),
    .req_valid       (eng_req_valid[ID_SETUP] ),
    .req_addr        (eng_req_addr[ID_SETUP]  ),
    .vertex_base     (vertex_base             ),
    .vertex_count    (vertex_count            ),
    .config_valid    (config_valid            ),
    .done            (setup_done              )
  );

  vertex_degree_reduce inst_vertex_degree_reduce (
    .ap_clk        (ap_clk                   ),
    .areset_control(areset_reduce            ),
    .config_valid  (config_valid             ),
    .vertex_base   (vertex_base              ),
    .vertex_count  (vertex_count             ),
    .req_grant     (eng_req_grant[ID_REDUCE] ),
    .resp_valid    (eng_resp_valid[ID_REDUCE]),
    .resp_data     (eng_resp_data            ),
    .req_valid     (eng_req_valid[ID_REDUCE] ),
    .req_addr      (eng_req_addr[ID_REDUCE]  ),
    .degree_sum    (degree_sum               ),
    .done          (reduce_done              )
  );

  completion_control #(
    .PULSE_HOLD(PULSE_HOLD)
  ) inst_completion_control (
    .ap_clk        (ap_clk           ),
    .areset_control(areset_completion),
    .reduce_done   (reduce_done      ),
    .setup_done    (setup_done       ),
    .fifo_empty    (fifo_empty       ),
    .flush         (flush            ),
    .done_out      (done_out         )
  );

endmodule : kernel_cu_top

// File: test/tb_clock_gen.sv
/* Testbench clock and reset */

`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 10
) (
  input  logic reset_request,
  output logic ap_clk,
  output logic areset_control
);

  int unsigned hold_cnt;

  // Reset starts asserted
  initial begin
    ap_clk         = 1'b0;
    areset_control = 1'b1;
    hold_cnt       = RESET_CYCLES;
  end

  always #(PERIOD_NS / 2) ap_clk = ~ap_clk;

  // Reset stays high for RESET_CYCLES rising edges after each request
  always @(posedge ap_clk) begin
    if (reset_request) begin
      hold_cnt       <= RESET_CYCLES;
      areset_control <= 1'b1;
    end else if (hold_cnt > 0) begin
      hold_cnt       <= hold_cnt - 1;
      areset_control <= (hold_cnt > 1);
    end
  end

endmodule : tb_clock_gen

// File: test/kernel_cu_checker.sv
/* Compute unit assertions */

`timescale 1ns/100ps

module kernel_cu_checker import kernel_cu_pkg::*; (
  input logic             ap_clk,
  input logic             areset_control,
  input logic             mem_req_valid,
  input logic             done_out,
  input logic [SUM_W-1:0] degree_sum
);

  // Tally of failed assertions
  int assert_failures = 0;

  // ----------------------------------------
  // Properties
  // ----------------------------------------

  // Registered reset fan-out needs two edges to clear the outputs
  property outputs_low_in_reset;
    @(posedge ap_clk) areset_control [*3] |-> (!done_out && !mem_req_valid);
  endproperty

  // Sticky done_out drops only two edges after reset
  property done_out_sticky;
    @(posedge ap_clk) $fell(done_out) |-> $past(areset_control, 2);
  endproperty

  // Result frozen once the unit reports done
  property sum_stable_when_done;
    @(posedge ap_clk) disable iff (areset_control)
      (done_out && $past(done_out)) |-> $stable(degree_sum);
  endproperty

  assert property (outputs_low_in_reset) else begin
    assert_failures++;
    $error("done_out or mem_req_valid high during reset");
  end

  assert property (done_out_sticky) else begin
    assert_failures++;
    $error("done_out fell without a reset");
  end

  assert property (sum_stable_when_done) else begin
    assert_failures++;
    $error("degree_sum changed while done_out was high");
  end

endmodule : kernel_cu_checker

// File: test/kernel_cu_tb.sv
/* Compute unit testbench */

`timescale 1ns/100ps

module kernel_cu_tb import kernel_cu_pkg::*;;

  localparam int          FIFO_DEPTH   = 8;
  localparam int          PULSE_HOLD   = 4;
  localparam int          GOLDEN_WORDS = 256;
  localparam int          MEM_WORDS    = 2 ** ADDR_W;
  localparam int          WORD_CYCLES  = 20;
  localparam int          TEST_MARGIN  = 150;
  localparam logic [31:0] SEED         = 32'h84ea;

  logic              ap_clk;
  logic              areset_control;
  logic              reset_request;
  logic              descriptor_valid;
  logic [ADDR_W-1:0] config_base;
  logic              mem_stall;
  logic              mem_resp_valid;
  logic [DATA_W-1:0] mem_resp_data;
  logic [ID_W-1:0]   mem_resp_id;
  logic              mem_req_valid;
  logic [ADDR_W-1:0] mem_req_addr;
  logic [ID_W-1:0]   mem_req_id;
  logic [SUM_W-1:0]  degree_sum;
  logic              done_out;

  // Golden records and memory image
  logic [31:0]       golden [GOLDEN_WORDS];
  logic [DATA_W-1:0] mem_image [MEM_WORDS];
  logic [7:0]        hits [MEM_WORDS];
  logic [7:0]        want_hits [MEM_WORDS];
  logic [ID_W-1:0]   want_id [MEM_WORDS];
  int                test_start [$];
  int unsigned       watchdog_cycles = 0;

  tb_clock_gen #(
    .PERIOD_NS   (4 ),
    .RESET_CYCLES(10)
  ) inst_clock_gen (
    .reset_request (reset_request ),
    .ap_clk        (ap_clk        ),
    .areset_control(areset_control)
  );

  kernel_cu_top #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .PULSE_HOLD(PULSE_HOLD)
  ) DUT (
    .ap_clk          (ap_clk          ),
    .areset_control  (areset_control  ),
    .descriptor_valid(descriptor_valid),
    .config_base     (config_base     ),
    .mem_stall       (mem_stall       ),
    .mem_resp_valid  (mem_resp_valid  ),
    .mem_resp_data   (mem_resp_data   ),
    .mem_resp_id     (mem_resp_id     ),
    .mem_req_valid   (mem_req_valid   ),
    .mem_req_addr    (mem_req_addr    ),
    .mem_req_id      (mem_req_id      ),
    .degree_sum      (degree_sum      ),
    .done_out        (done_out        )
  );

  bind kernel_cu_top kernel_cu_checker inst_checker (
    .ap_clk        (ap_clk        ),
    .areset_control(areset_control),
    .mem_req_valid (mem_req_valid ),
    .done_out      (done_out      ),
    .degree_sum    (degree_sum    )
  );

  // ----------------------------------------
  // Checks and failure exits
  // ----------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "run aborted");
  endtask

  // Each read is expected once, with the ID of its engine
  task automatic log_request(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id);
    hits[addr] = hits[addr] + 8'd1;
    if (hits[addr] > want_hits[addr]) begin
      check_value($sformatf("mem_req_addr %h request count", addr), want_hits[addr], hits[addr]);
    end
    if (want_hits[addr] != 0) begin
      check_value("mem_req_id", want_id[addr], id);
    end
  endtask

  task automatic apply_reset();
    reset_request <= 1'b1;
    @(posedge ap_clk);
    reset_request <= 1'b0;
    @(posedge ap_clk);
    while (areset_control) begin
      @(posedge ap_clk);
    end
  endtask

  // ----------------------------------------
  // One golden test
  // ----------------------------------------
  task automatic run_test(input int pos);
    logic [ADDR_W-1:0] cb;
    logic [ADDR_W-1:0] vb;
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] cnt;
    logic [SUM_W-1:0]  model_sum;
    logic [SUM_W-1:0]  gold_sum;
    int                n;
    int                w;
    int unsigned       i;
    cb       = golden[pos][ADDR_W-1:0];
    gold_sum = golden[pos+1];
    n        = golden[pos+2];
    // Fill pattern from the full address, then the listed words
    for (w = 0; w < MEM_WORDS; w++) begin
      mem_image[w] = {16'(w), ~16'(w)};
      hits[w]      = '0;
      want_hits[w] = '0;
      want_id[w]   = '0;
    end
    for (w = 0; w < n; w++) begin
      mem_image[golden[pos+3+2*w][ADDR_W-1:0]] = golden[pos+4+2*w];
    end
    // Expected reads and sum from the configuration block
    vb  = mem_image[cb + CFG_VERTEX_BASE][ADDR_W-1:0];
    cnt = mem_image[cb + CFG_VERTEX_COUNT];
    for (i = 0; i < CFG_WORDS; i++) begin
      want_hits[cb + ADDR_W'(i)] = 8'd1;
      want_id[cb + ADDR_W'(i)]   = ID_W'(ID_SETUP);
    end
    model_sum = '0;
    for (i = 0; i < cnt; i++) begin
      a            = vb + ADDR_W'(i);
      want_hits[a] = 8'd1;
      want_id[a]   = ID_W'(ID_REDUCE);
      model_sum    = model_sum + mem_image[a];
    end
    check_value("golden expected sum", model_sum, gold_sum);

    apply_reset();
    // Let the registered reset copies release
    repeat (3) @(posedge ap_clk);
    check_value("done_out", 32'd0, 32'(done_out));
    check_value("degree_sum", 32'd0, degree_sum);
    config_base      <= cb;
    descriptor_valid <= 1'b1;
    @(posedge ap_clk);
    descriptor_valid <= 1'b0;
    while (done_out !== 1'b1) begin
      @(posedge ap_clk);
    end
    check_value("degree_sum", gold_sum, degree_sum);
    for (w = 0; w < MEM_WORDS; w++) begin
      if (want_hits[w] != 0) begin
        check_value($sformatf("mem_req_addr %h request count", w), want_hits[w], hits[w]);
      end
    end
  endtask

  // ----------------------------------------
  // Memory model, in-order answers
  // ----------------------------------------
  initial begin : memory_model
    logic [ADDR_W-1:0] addr_q [$];
    logic [ID_W-1:0]   id_q [$];
    logic [ADDR_W-1:0] head_addr;
    int unsigned       resp_wait;
    void'($urandom(SEED));
    mem_stall      = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_data  = '0;
    mem_resp_id    = '0;
    resp_wait      = 0;
    forever begin
      @(posedge ap_clk);
      mem_resp_valid <= 1'b0;
      mem_stall      <= ($urandom_range(3) == 0);
      if (areset_control) begin
        addr_q.delete();
        id_q.delete();
        resp_wait = 0;
      end else begin
        if (mem_req_valid === 1'b1) begin
          log_request(mem_req_addr, mem_req_id);
          addr_q.push_back(mem_req_addr);
          id_q.push_back(mem_req_id);
        end
        // Random gap between consecutive answers
        if (resp_wait > 0) begin
          resp_wait--;
        end else if (addr_q.size() > 0) begin
          head_addr = addr_q.pop_front();
          mem_resp_valid <= 1'b1;
          mem_resp_data  <= mem_image[head_addr];
          mem_resp_id    <= id_q.pop_front();
          resp_wait = $urandom_range(3);
        end
      end
    end
  end

  // Watchdog sized from the golden word counts
  initial begin : watchdog
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge ap_clk);
    abort_run($sformatf("Timeout: tests did not finish within %0d cycles", watchdog_cycles));
  end

  // Any failed bound assertion ends the run
  initial begin : assertion_monitor
    wait (DUT.inst_checker.assert_failures != 0);
    abort_run("An assertion in kernel_cu_checker failed");
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : main_sequence
    int          pos;
    int          t;
    int unsigned limit;
    reset_request    = 1'b0;
    descriptor_valid = 1'b0;
    config_base      = '0;
    $readmemh("test/kernel_cu_golden.txt", golden);
    if ($isunknown(golden[0])) begin
      abort_run("Golden file could not be read");
    end
    // Record layout is config_base, sum, word count, then address and data pairs
    pos   = 1;
    limit = 0;
    for (t = 0; t < golden[0]; t++) begin
      test_start.push_back(pos);
      limit = limit + WORD_CYCLES * golden[pos+2] + TEST_MARGIN;
      pos   = pos + 3 + 2 * golden[pos+2];
    end
    watchdog_cycles = limit;
    foreach (test_start[k]) begin
      run_test(test_start[k]);
    end
    if (DUT.inst_checker.assert_failures == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : kernel_cu_tb

// File: test/kernel_cu_golden.txt
// Test count, then per test: config_base expected_sum word_count
// followed by word_count pairs of memory address and data word
5
0010 00000010 6
0010 00000100 0011 00000004
0100 00000003 0101 00000005 0102 00000001 0103 00000007
0020 00000000 2
0020 00000200 0021 00000000
0030 00000050 a
0030 00000300 0031 00000008
0300 0000000a 0301 00000014 0302 00000003 0303 00000000
0304 0000001f 0305 00000008 0306 00000002 0307 00000006
1000 0000052e e
1000 00002000 1001 0000000c
2000 00000011 2001 00000022 2002 00000033 2003 00000044
2004 00000055 2005 00000066 2006 00000077 2007 00000088
2008 00000099 2009 000000aa 200a 000000bb 200b 000000cc
ff00 80000001 3
ff00 0000fffe ff01 00000001 fffe 80000001

// File: filelist.f
source/kernel_cu_pkg.sv
source/sync_fifo.sv
source/request_arbiter.sv
source/response_router.sv
source/cu_setup.sv
source/vertex_degree_reduce.sv
source/completion_control.sv
source/kernel_cu_top.sv
test/tb_clock_gen.sv
test/kernel_cu_checker.sv
test/kernel_cu_tb.sv
